// File: all.f
rtl/audio_pkg.sv
rtl/audio_mixer.sv
rtl/audio_compressor.sv
rtl/audio_out.sv
verification/tb_clock.sv
verification/audio_tb.sv

// File: rtl/audio_compressor.sv
// Output stage: takes the sample from the mix word and applies the selected two-knee boost curve
`timescale 1ns/1ns

module audio_compressor #(
	parameter int LIGHT_RATIO = 4,  // Slope divider above the knee, 2x setting
	parameter int LIGHT_GAIN  = 2,  // Gain below the knee, 2x setting
	parameter int HEAVY_RATIO = 8,
	parameter int HEAVY_GAIN  = 4
) (
	input  logic               clk_sys,
	input  logic               reset,

	// Mixed input from the mixer
	input  logic               mix_stb,
	input  audio_pkg::mix_t    mix_l,
	input  audio_pkg::mix_t    mix_r,

	input  audio_pkg::boost_t  master_boost,

	// Final stereo sample
	output audio_pkg::sample_t audio_l,
	output audio_pkg::sample_t audio_r,
	output logic               out_stb
);
	import audio_pkg::*;

	// Unsigned magnitude of a sample
	typedef logic [$bits(sample_t)-1:0] mag_t;

	////////////////////////////////////////////////////////////////////////////
	// Curve constants

	// Knee rounded up, the upper segment then ends exactly at SAMPLE_MAX
	localparam mag_t LIGHT_KNEE =
		mag_t'((SAMPLE_MAX * (LIGHT_RATIO - 1) - 1) / (LIGHT_RATIO * LIGHT_GAIN - 1) + 1);
	localparam mag_t LIGHT_OFFSET = mag_t'(LIGHT_KNEE * LIGHT_GAIN);

	localparam mag_t HEAVY_KNEE =
		mag_t'((SAMPLE_MAX * (HEAVY_RATIO - 1) - 1) / (HEAVY_RATIO * HEAVY_GAIN - 1) + 1);
	localparam mag_t HEAVY_OFFSET = mag_t'(HEAVY_KNEE * HEAVY_GAIN);

	localparam mag_t LIGHT_R = mag_t'(LIGHT_RATIO);
	localparam mag_t LIGHT_G = mag_t'(LIGHT_GAIN);
	localparam mag_t HEAVY_R = mag_t'(HEAVY_RATIO);
	localparam mag_t HEAVY_G = mag_t'(HEAVY_GAIN);

	// Two segments on the magnitude, sign put back afterwards
	function automatic sample_t compress(
		input sample_t x,
		input mag_t    knee,
		input mag_t    offset,
		input mag_t    ratio,
		input mag_t    gain
	);
		mag_t mag;
		mag_t v;
		mag = x[$bits(sample_t)-1] ? mag_t'(-x) : mag_t'(x);
		if (mag < knee) begin
			v = mag * gain;                    // Linear gain part
		end else begin
			v = (mag - knee) / ratio + offset; // Flattened upper part
		end
		return x[$bits(sample_t)-1] ? sample_t'(-v) : sample_t'(v);
	endfunction

	sample_t samp_l;
	sample_t samp_r;
	sample_t cmp_l;
	sample_t cmp_r;

	////////////////////////////////////////////////////////////////////////////
	// Curve select

	// Headroom bits dropped here
	assign samp_l = mix_l[HEADROOM_BITS +: $bits(sample_t)];
	assign samp_r = mix_r[HEADROOM_BITS +: $bits(sample_t)];

	always_comb begin
		case (master_boost)
			BOOST_NONE: begin
				cmp_l = samp_l;
				cmp_r = samp_r;
			end
			BOOST_2X: begin
				cmp_l = compress(samp_l, LIGHT_KNEE, LIGHT_OFFSET, LIGHT_R, LIGHT_G);
				cmp_r = compress(samp_r, LIGHT_KNEE, LIGHT_OFFSET, LIGHT_R, LIGHT_G);
			end
			default: begin // 4x
				cmp_l = compress(samp_l, HEAVY_KNEE, HEAVY_OFFSET, HEAVY_R, HEAVY_G);
				cmp_r = compress(samp_r, HEAVY_KNEE, HEAVY_OFFSET, HEAVY_R, HEAVY_G);
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Output register

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			out_stb <= 1'b0;
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			out_stb <= mix_stb;
			if (mix_stb) begin    // Held between strobes
				audio_l <= cmp_l;
				audio_r <= cmp_r;
			end
		end
	end

endmodule

// File: rtl/audio_mixer.sv
// Two-stage mixer that sums CD, PSG and ADPCM with optional CD boost and scales to full range
`timescale 1ns/1ns

module audio_mixer (
	input  logic               clk_sys,
	input  logic               reset,

	// Source samples valid with sample_stb
	input  logic               sample_stb,
	input  audio_pkg::sample_t cdda_l,
	input  audio_pkg::sample_t cdda_r,
	input  audio_pkg::sample_t psg_l,
	input  audio_pkg::sample_t psg_r,
	input  audio_pkg::sample_t adpcm,

	input  logic               cd_boost,   // CD counted twice and no range scaling

	// Mixed result two cycles after sample_stb
	output logic               mix_stb,
	output audio_pkg::mix_t    mix_l,
	output audio_pkg::mix_t    mix_r
);
	import audio_pkg::*;

	// Sign extension of a sample into the headroom word
	function automatic mix_t widen(input sample_t s);
		return {{HEADROOM_BITS{s[$bits(sample_t)-1]}}, s};
	endfunction

	// Sum plus a quarter of itself
	function automatic mix_t five_quarters(input mix_t s);
		return s + (s >>> 2);
	endfunction

	mix_t cd_l;
	mix_t cd_r;
	mix_t cd_extra_l;
	mix_t cd_extra_r;
	mix_t adpcm_w;

	mix_t sum_l;
	mix_t sum_r;
	logic sum_stb;

	////////////////////////////////////////////////////////////////////////////
	// Stage 1 source sum

	assign cd_l    = widen(cdda_l);
	assign cd_r    = widen(cdda_r);
	assign adpcm_w = widen(adpcm);     // Mono sample lands on both sides

	// Second copy of the CD sample only with the boost
	assign cd_extra_l = cd_boost ? cd_l : mix_t'(0);
	assign cd_extra_r = cd_boost ? cd_r : mix_t'(0);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sum_stb <= 1'b0;
			sum_l   <= '0;
			sum_r   <= '0;
		end else begin
			sum_stb <= sample_stb;
			if (sample_stb) begin
				sum_l <= cd_l + cd_extra_l + widen(psg_l) + adpcm_w;
				sum_r <= cd_r + cd_extra_r + widen(psg_r) + adpcm_w;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage 2 range scaling

	// Without the CD boost the sum never reaches full scale and gets stretched
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mix_stb <= 1'b0;
			mix_l   <= '0;
			mix_r   <= '0;
		end else begin
			mix_stb <= sum_stb;
			if (sum_stb) begin
				if (cd_boost) begin
					mix_l <= sum_l;
					mix_r <= sum_r;
				end else begin
					mix_l <= five_quarters(sum_l);
					mix_r <= five_quarters(sum_r);
				end
			end
		end
	end

endmodule

// File: rtl/audio_out.sv
// Audio output stage top: mixer followed by the master-boost compressor, three cycles strobe to strobe
`timescale 1ns/1ns

module audio_out #(
	// Compressor curves
	parameter int LIGHT_RATIO = 4,
	parameter int LIGHT_GAIN  = 2,
	parameter int HEAVY_RATIO = 8,
	parameter int HEAVY_GAIN  = 4
) (
	input  logic               clk_sys,
	input  logic               reset,

	// One sample set per strobe, no back-pressure
	input  logic               sample_stb,
	input  audio_pkg::sample_t cdda_l,
	input  audio_pkg::sample_t cdda_r,
	input  audio_pkg::sample_t psg_l,
	input  audio_pkg::sample_t psg_r,
	input  audio_pkg::sample_t adpcm,

	// Quasi-static settings
	input  logic               cd_boost,
	input  audio_pkg::boost_t  master_boost,

	// Signed stereo result
	output audio_pkg::sample_t audio_l,
	output audio_pkg::sample_t audio_r,
	output logic               out_stb
);
	import audio_pkg::*;

	// Mixer to compressor
	logic mix_stb;
	mix_t mix_l;
	mix_t mix_r;

	////////////////////////////////////////////////////////////////////////////
	// Stages 1 and 2

	audio_mixer mixer_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.sample_stb (sample_stb),
		.cdda_l     (cdda_l),
		.cdda_r     (cdda_r),
		.psg_l      (psg_l),
		.psg_r      (psg_r),
		.adpcm      (adpcm),
		.cd_boost   (cd_boost),
		.mix_stb    (mix_stb),
		.mix_l      (mix_l),
		.mix_r      (mix_r)
	);

	////////////////////////////////////////////////////////////////////////////
	// Stage 3

	audio_compressor #(
		.LIGHT_RATIO (LIGHT_RATIO),
		.LIGHT_GAIN  (LIGHT_GAIN),
		.HEAVY_RATIO (HEAVY_RATIO),
		.HEAVY_GAIN  (HEAVY_GAIN)
	) compressor_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.mix_stb      (mix_stb),
		.mix_l        (mix_l),
		.mix_r        (mix_r),
		.master_boost (master_boost),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.out_stb      (out_stb)
	);

endmodule

// File: rtl/audio_pkg.sv
// Sample widths, mix headroom and master-boost codes shared by the audio output stage
package audio_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sample types

	// Signed source or output sample
	typedef logic signed [15:0] sample_t;

	// Signed mixed sum carrying extra headroom above a sample
	typedef logic signed [17:0] mix_t;

	// Extra mix bits above a sample, dropped when the sample is taken
	localparam int HEADROOM_BITS = 2;

	// Largest positive sample magnitude, the top of every compressor curve
	localparam int SAMPLE_MAX = 32767;

	////////////////////////////////////////////////////////////////////////////
	// Master boost

	typedef logic [1:0] boost_t;

	localparam boost_t BOOST_NONE = 2'd0;  // Compressor bypassed
	localparam boost_t BOOST_2X   = 2'd1;  // Light curve
	// Codes 2 and 3 both select the heavy curve

endpackage

// File: verification/audio_tb.sv
// Testbench for audio_out with random and directed samples, reference model and timing checks
`timescale 1ns/1ns

module audio_tb;
	import audio_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Run length and curve constants

	localparam int N_MIXED       = 200;
	localparam int N_CD          = 40;
	localparam int DIRECTED_CD   = 4;
	localparam int N_CURVE       = 40;
	localparam int DIRECTED_KNEE = 9;
	localparam int N_BURST       = 100;
	localparam int TOTAL_STROBES = N_MIXED + N_CD + DIRECTED_CD
		+ 2 * (N_CURVE + DIRECTED_KNEE) + 4 * N_BURST;
	localparam int CYCLE_LIMIT   = 4 * TOTAL_STROBES + 100;

	// Knee and upper offset of the default curves
	localparam int KNEE_LIGHT   = 14043;
	localparam int OFFSET_LIGHT = 28086;
	localparam int KNEE_HEAVY   = 7399;
	localparam int OFFSET_HEAVY = 29596;

	logic    clk_sys;
	logic    reset;
	logic    sample_stb;
	sample_t cdda_l;
	sample_t cdda_r;
	sample_t psg_l;
	sample_t psg_r;
	sample_t adpcm;
	logic    cd_boost;
	boost_t  master_boost;
	sample_t audio_l;
	sample_t audio_r;
	logic    out_stb;

	sample_t     exp_l_q[$];
	sample_t     exp_r_q[$];
	sample_t     held_l = '0;        // Last expected result held between strobes
	sample_t     held_r = '0;
	logic [2:0]  stb_hist = 3'b000;  // sample_stb of the last three cycles
	logic        idle_check = 1'b0;
	logic [31:0] rng = 32'hd528;
	int          mismatch_errors = 0;
	int          protocol_errors = 0;
	int          cycles = 0;

	tb_clock clock_inst (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	audio_out audio_out_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.sample_stb   (sample_stb),
		.cdda_l       (cdda_l),
		.cdda_r       (cdda_r),
		.psg_l        (psg_l),
		.psg_r        (psg_r),
		.adpcm        (adpcm),
		.cd_boost     (cd_boost),
		.master_boost (master_boost),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.out_stb      (out_stb)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Sum with 2 bits of headroom and take the top 16 bits
	function automatic sample_t mix_ref(input sample_t cd, input sample_t psg,
		input sample_t ad, input logic boost_cd);
		int sum;
		sum = int'(cd) + int'(psg) + int'(ad);
		if (boost_cd)
			sum = sum + int'(cd);      // CD counted twice
		else
			sum = sum + (sum >>> 2);   // 5/4 range stretch
		return sample_t'(sum >>> 2);
	endfunction

	function automatic sample_t compress_ref(input sample_t x, input int knee,
		input int offset, input int ratio, input int gain);
		int mag;
		int v;
		mag = (x < 0) ? -int'(x) : int'(x);
		if (mag < knee)
			v = mag * gain;
		else
			v = (mag - knee) / ratio + offset;
		return (x < 0) ? sample_t'(-v) : sample_t'(v);
	endfunction

	function automatic sample_t expected_out(input sample_t cd, input sample_t psg,
		input sample_t ad, input logic boost_cd, input boost_t boost);
		sample_t s;
		sample_t r;
		s = mix_ref(cd, psg, ad, boost_cd);
		if (boost == BOOST_NONE)
			r = s;
		else if (boost == BOOST_2X)
			r = compress_ref(s, KNEE_LIGHT, OFFSET_LIGHT, 4, 2);
		else
			r = compress_ref(s, KNEE_HEAVY, OFFSET_HEAVY, 8, 4);
		return r;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus tasks

	task automatic send_sample(input sample_t cl, input sample_t cr, input sample_t pl,
		input sample_t pr, input sample_t ad, input int gap);
		@(posedge clk_sys);
		sample_stb <= 1'b1;
		cdda_l     <= cl;
		cdda_r     <= cr;
		psg_l      <= pl;
		psg_r      <= pr;
		adpcm      <= ad;
		exp_l_q.push_back(expected_out(cl, pl, ad, cd_boost, master_boost));
		exp_r_q.push_back(expected_out(cr, pr, ad, cd_boost, master_boost));
		repeat (gap) begin
			@(posedge clk_sys);
			sample_stb <= 1'b0;
		end
	endtask

	// With the CD boost all five sources at one level land exactly on that level
	task automatic send_level(input sample_t s);
		send_sample(s, s, s, s, s, 0);
	endtask

	task automatic random_samples(input int count, input logic with_gaps);
		sample_t cl;
		sample_t cr;
		sample_t pl;
		sample_t pr;
		sample_t ad;
		int gap;
		for (int i = 0; i < count; i++) begin
			rng = xorshift(rng);
			cl  = rng[15:0];
			cr  = rng[31:16];
			rng = xorshift(rng);
			pl  = rng[15:0];
			pr  = rng[31:16];
			rng = xorshift(rng);
			ad  = rng[15:0];
			gap = with_gaps ? int'(rng[17:16]) : 0;
			send_sample(cl, cr, pl, pr, ad, gap);
		end
	endtask

	task automatic drain_pipeline();
		@(posedge clk_sys);
		sample_stb <= 1'b0;
		while (exp_l_q.size() > 0) @(posedge clk_sys);
	endtask

	// Only called with an empty pipeline
	task automatic set_mode(input logic boost_cd, input boost_t boost);
		@(posedge clk_sys);
		cd_boost     <= boost_cd;
		master_boost <= boost;
	endtask

	task automatic knee_levels(input int knee);
		send_level(sample_t'(knee - 1));
		send_level(sample_t'(knee));
		send_level(sample_t'(knee + 1));
		send_level(sample_t'(-(knee - 1)));
		send_level(sample_t'(-knee));
		send_level(sample_t'(-(knee + 1)));
		send_level(16'sd0);
		send_level(16'sd32767);
		send_level(-16'sd32768);
	endtask

	task automatic report_mismatch(input string name, input sample_t exp, input sample_t act);
		mismatch_errors++;
		$display("MISMATCH at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output checks sampled mid-cycle

	always @(negedge clk_sys) begin
		sample_t el;
		sample_t er;
		if (idle_check) begin
			assert (out_stb === 1'b0) else begin
				protocol_errors++;
				$display("%0t ns: out_stb high with no sample sent", $time);
			end
			assert (audio_l === 16'sd0) else report_mismatch("audio_l", 16'sd0, audio_l);
			assert (audio_r === 16'sd0) else report_mismatch("audio_r", 16'sd0, audio_r);
		end
		assert (out_stb === stb_hist[2]) else begin
			protocol_errors++;
			if (stb_hist[2])
				$display("%0t ns: no out_stb three cycles after sample_stb", $time);
			else
				$display("%0t ns: out_stb without a sample_stb three cycles before", $time);
		end
		if (out_stb === 1'b1) begin
			if (exp_l_q.size() == 0) begin
				protocol_errors++;
				$display("%0t ns: out_stb while no sample was pending", $time);
			end else begin
				el = exp_l_q.pop_front();
				er = exp_r_q.pop_front();
				assert (audio_l === el) else report_mismatch("audio_l", el, audio_l);
				assert (audio_r === er) else report_mismatch("audio_r", er, audio_r);
				held_l = el;
				held_r = er;
			end
		end else if (!idle_check) begin
			// Outputs keep the last result between strobes
			assert (audio_l === held_l) else report_mismatch("audio_l", held_l, audio_l);
			assert (audio_r === held_r) else report_mismatch("audio_r", held_r, audio_r);
		end
		stb_hist <= {stb_hist[1:0], sample_stb};
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles with %0d results outstanding",
				cycles, exp_l_q.size());
			$display("*** FAILED ***");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		sample_stb   <= 1'b0;
		cdda_l       <= '0;
		cdda_r       <= '0;
		psg_l        <= '0;
		psg_r        <= '0;
		adpcm        <= '0;
		cd_boost     <= 1'b0;
		master_boost <= BOOST_NONE;
		idle_check   <= 1'b1;

		// Reset and quiet period
		while (reset !== 1'b0) @(posedge clk_sys);
		repeat (8) @(posedge clk_sys);
		idle_check <= 1'b0;

		// Plain mix with random gaps
		random_samples(N_MIXED, 1'b1);
		drain_pipeline();

		// CD boost with full scale at both ends for the headroom
		set_mode(1'b1, BOOST_NONE);
		send_level(-16'sd32768);
		send_level(16'sd32767);
		send_sample(-16'sd32768, 16'sd32767, 16'sd0, 16'sd0, -16'sd32768, 0);
		send_sample(16'sd32767, -16'sd32768, -16'sd32768, 16'sd32767, 16'sd0, 1);
		random_samples(N_CD, 1'b1);
		drain_pipeline();

		// Light and heavy curves around their knees
		for (int c = 0; c < 2; c++) begin
			set_mode(1'b1, (c == 0) ? BOOST_2X : boost_t'(3));
			knee_levels((c == 0) ? KNEE_LIGHT : KNEE_HEAVY);
			drain_pipeline();
			set_mode(1'b0, (c == 0) ? BOOST_2X : boost_t'(3));
			random_samples(N_CURVE, 1'b1);
			drain_pipeline();
		end

		// Back-to-back bursts for every boost code
		for (int m = 0; m < 4; m++) begin
			set_mode(m[0], boost_t'(m));
			random_samples(N_BURST, 1'b0);
			drain_pipeline();
		end

		repeat (5) @(posedge clk_sys);
		$display("Errors: %0d mismatch, %0d protocol", mismatch_errors, protocol_errors);
		if (mismatch_errors == 0 && protocol_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: verification/tb_clock.sv
// Testbench clock and reset source, drives clk_sys and holds reset over the first rising edges
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD       = 20,  // ns
	parameter int RESET_CYCLES = 4
) (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD / 2) clk_sys = ~clk_sys;
	end

	// Released on a rising edge so the DUT sees a clean synchronous release
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset <= 1'b0;
	end

endmodule
